// ==== verilog/l1_trig_cfg.svh ====
`ifndef L1_TRIG_CFG_SVH
`define L1_TRIG_CFG_SVH

// number of beams fed to the trigger
`define L1_NBEAMS 2

// beam power word, also the threshold width
`define L1_POW_W 18

// per-beam scaler counter width
`define L1_SCAL_W 16

// register bus address and data widths
`define L1_ADR_W 13
`define L1_DAT_W 32

// scaler measurement period, in clock cycles
`define L1_PERIOD_W 20

// period loaded at reset
`define L1_PERIOD_RST 64

`endif

// ==== verilog/l1_trig_pkg.sv ====
`include "l1_trig_cfg.svh"

package l1_trig_pkg;

    // one beam power word, or one threshold
    typedef logic [`L1_POW_W-1:0] beam_pow_t;

    // one bit per beam
    typedef logic [`L1_NBEAMS-1:0] beam_mask_t;

    // single scaler value
    typedef logic [`L1_SCAL_W-1:0] scal_cnt_t;

    // register bus address and data
    typedef logic [`L1_ADR_W-1:0] bus_adr_t;
    typedef logic [`L1_DAT_W-1:0] bus_dat_t;

    // scaler period count
    typedef logic [`L1_PERIOD_W-1:0] period_t;

endpackage

// ==== verilog/l1_bus_if.sv ====
// internal register bus between the decode stage and one slave
interface l1_bus_if;
    import l1_trig_pkg::*;

    // one-cycle access request from the decode stage
    logic     cyc;
    logic     we;
    bus_adr_t adr;
    bus_dat_t wdat;

    // slave answers in the same cycle
    bus_dat_t rdat;
    logic     ack;

    modport master (
        output cyc,
        output we,
        output adr,
        output wdat,
        input  rdat,
        input  ack
    );

    modport slave (
        input  cyc,
        input  we,
        input  adr,
        input  wdat,
        output rdat,
        output ack
    );

endinterface

// ==== verilog/l1_reg_decode.sv ====
module l1_reg_decode (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  bus_cyc_i,
    input  logic                  bus_we_i,
    input  l1_trig_pkg::bus_adr_t bus_adr_i,
    input  l1_trig_pkg::bus_dat_t bus_dat_i,
    output l1_trig_pkg::bus_dat_t bus_dat_o,
    output logic                  bus_ack_o,
    input  logic                  bank_i,
    l1_bus_if.master              thr_m,
    l1_bus_if.master              scal_m
);
    import l1_trig_pkg::*;

    logic     busy_q;
    logic     ack_q;
    logic     first;
    logic     thr_sel;
    bus_adr_t fwd_adr;
    bus_dat_t rdat_q;

    // only the first cycle of a held cyc reaches the slaves
    assign first   = bus_cyc_i && !busy_q;
    assign thr_sel = bus_adr_i[11];

    // bit 11 is consumed by the split, bit 12 moves down to bit 11
    assign fwd_adr = {1'b0, bus_adr_i[12], bus_adr_i[10:0]};

    assign thr_m.cyc  = first && thr_sel;
    assign thr_m.we   = bus_we_i;
    assign thr_m.adr  = fwd_adr;
    assign thr_m.wdat = bus_dat_i;

    assign scal_m.cyc  = first && !thr_sel;
    assign scal_m.we   = bus_we_i;
    assign scal_m.adr  = fwd_adr;
    assign scal_m.wdat = bus_dat_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            ack_q  <= 1'b0;
        end else begin
            busy_q <= bus_cyc_i;
            ack_q  <= thr_m.ack || scal_m.ack;
        end
    end

    // read data is captured alongside the ack, scaler reads carry the bank in the msb
    always_ff @(posedge clk_i) begin
        if (first) begin
            if (thr_sel) begin
                rdat_q <= thr_m.rdat;
            end else begin
                rdat_q <= {bank_i, scal_m.rdat[$bits(bus_dat_t)-2:0]};
            end
        end
    end

    assign bus_ack_o = ack_q;
    assign bus_dat_o = rdat_q;

    // a held cyc must never produce a second ack
    assert property (@(posedge clk_i) disable iff (!rst_n_i) bus_ack_o |=> !bus_ack_o)
        else $error("bus ack high on two consecutive cycles");

endmodule

// ==== verilog/beam_thresh_trigger.sv ====
`include "l1_trig_cfg.svh"

module beam_thresh_trigger (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    l1_bus_if.slave                                 bus_s,
    input  l1_trig_pkg::beam_pow_t [`L1_NBEAMS-1:0] beam_pow_i,
    output l1_trig_pkg::beam_mask_t                 trigger_o,
    output l1_trig_pkg::beam_mask_t                 subthresh_o,
    output l1_trig_pkg::period_t                    period_o
);
    import l1_trig_pkg::*;

    // control offsets inside threshold space
    localparam logic [10:0] UPDATE_OFS = 11'h400;
    localparam logic [10:0] PERIOD_OFS = 11'h401;
    localparam int          IDX_W      = (`L1_NBEAMS > 1) ? $clog2(`L1_NBEAMS) : 1;

    // index 0 is the real side, index 1 the subthreshold side
    beam_pow_t  pend_q [2][`L1_NBEAMS];
    beam_pow_t  act_q  [2][`L1_NBEAMS];
    period_t    period_q;
    beam_mask_t trig_q;
    beam_mask_t sub_q;

    logic       side;
    logic       ctrl_sp;
    logic [9:0] beam_sel;
    logic       beam_ok;
    logic       wr;

    assign side     = bus_s.adr[11];
    assign ctrl_sp  = bus_s.adr[10];
    assign beam_sel = bus_s.adr[9:0];
    assign beam_ok  = beam_sel < 10'(`L1_NBEAMS);
    assign wr       = bus_s.cyc && bus_s.we;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < 2; s++) begin
                for (int b = 0; b < `L1_NBEAMS; b++) begin
                    pend_q[s][b] <= '1;
                    act_q[s][b]  <= '1;
                end
            end
            period_q <= period_t'(`L1_PERIOD_RST);
        end else begin
            if (wr && !ctrl_sp && beam_ok) begin
                pend_q[side][beam_sel[IDX_W-1:0]] <= bus_s.wdat[`L1_POW_W-1:0];
            end
            // update strobe moves the whole pending set live at once
            if (wr && bus_s.adr[10:0] == UPDATE_OFS) begin
                act_q <= pend_q;
            end
            if (wr && bus_s.adr[10:0] == PERIOD_OFS) begin
                period_q <= bus_s.wdat[`L1_PERIOD_W-1:0];
            end
        end
    end

    // strictly greater than the active threshold
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            trig_q <= '0;
            sub_q  <= '0;
        end else begin
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                trig_q[b] <= beam_pow_i[b] > act_q[0][b];
                sub_q[b]  <= beam_pow_i[b] > act_q[1][b];
            end
        end
    end

    // readback of the pending set or the period
    always_comb begin
        bus_s.rdat = '0;
        if (!ctrl_sp) begin
            if (beam_ok) begin
                bus_s.rdat = bus_dat_t'(pend_q[side][beam_sel[IDX_W-1:0]]);
            end
        end else if (bus_s.adr[10:0] == PERIOD_OFS) begin
            bus_s.rdat = bus_dat_t'(period_q);
        end
    end

    assign bus_s.ack   = bus_s.cyc;
    assign trigger_o   = trig_q;
    assign subthresh_o = sub_q;
    assign period_o    = period_q;

    // the decode stage must never hand over a threshold write past the beam count
    assert property (@(posedge clk_i) disable iff (!rst_n_i) (wr && !ctrl_sp) |-> beam_ok)
        else $error("threshold write to beam index %0d", beam_sel);

endmodule

// ==== verilog/beam_scaler.sv ====
`include "l1_trig_cfg.svh"

module beam_scaler (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    l1_bus_if.slave                 bus_s,
    input  l1_trig_pkg::beam_mask_t trigger_i,
    input  l1_trig_pkg::beam_mask_t subthresh_i,
    input  l1_trig_pkg::period_t    period_i,
    output logic                    count_done_o,
    output logic                    bank_o
);
    import l1_trig_pkg::*;

    localparam int IDX_W = (`L1_NBEAMS > 1) ? $clog2(`L1_NBEAMS) : 1;

    // index 0 counts real triggers, index 1 subthreshold hits
    scal_cnt_t  cnt_q      [2][`L1_NBEAMS];
    scal_cnt_t  bank_cnt_q [2][`L1_NBEAMS];
    beam_mask_t hits       [2];

    period_t    tmr_q;
    period_t    period_prev_q;
    logic       restart;
    logic       last_cyc;
    logic       done_q;
    logic       bank_q;

    logic       side;
    logic [9:0] beam_sel;
    logic       beam_ok;

    assign hits[0] = trigger_i;
    assign hits[1] = subthresh_i;

    // a new period value restarts the measurement
    assign restart = period_i != period_prev_q;

    // timer never wraps out of zero, so a period is at least two cycles
    assign last_cyc = (tmr_q != '0) && (tmr_q >= period_i - period_t'(1));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tmr_q         <= '0;
            period_prev_q <= period_t'(`L1_PERIOD_RST);
            done_q        <= 1'b0;
            bank_q        <= 1'b0;
        end else begin
            period_prev_q <= period_i;
            done_q        <= 1'b0;
            if (restart || last_cyc) begin
                tmr_q <= '0;
            end else begin
                tmr_q <= tmr_q + period_t'(1);
            end
            if (!restart && last_cyc) begin
                done_q <= 1'b1;
                bank_q <= !bank_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < 2; s++) begin
                for (int b = 0; b < `L1_NBEAMS; b++) begin
                    cnt_q[s][b]      <= '0;
                    bank_cnt_q[s][b] <= '0;
                end
            end
        end else begin
            for (int s = 0; s < 2; s++) begin
                for (int b = 0; b < `L1_NBEAMS; b++) begin
                    if (restart || last_cyc) begin
                        // new period starts with this cycle's hit
                        cnt_q[s][b] <= scal_cnt_t'(hits[s][b]);
                    end else if (cnt_q[s][b] != '1) begin
                        cnt_q[s][b] <= cnt_q[s][b] + scal_cnt_t'(hits[s][b]);
                    end
                    if (!restart && last_cyc) begin
                        bank_cnt_q[s][b] <= cnt_q[s][b];
                    end
                end
            end
        end
    end

    assign side     = bus_s.adr[11];
    assign beam_sel = bus_s.adr[9:0];
    assign beam_ok  = beam_sel < 10'(`L1_NBEAMS);

    // reads come from the finished bank only, writes are ignored
    always_comb begin
        bus_s.rdat = '0;
        if (beam_ok) begin
            bus_s.rdat = bus_dat_t'(bank_cnt_q[side][beam_sel[IDX_W-1:0]]);
        end
    end

    assign bus_s.ack    = bus_s.cyc;
    assign count_done_o = done_q;
    assign bank_o       = bank_q;

    // done and the bank flip must stay a single pulse per period
    assert property (@(posedge clk_i) disable iff (!rst_n_i) count_done_o |=> !count_done_o)
        else $error("count_done_o high on two consecutive cycles");

endmodule

// ==== verilog/l1_trigger_top.sv ====
`include "l1_trig_cfg.svh"

module l1_trigger_top (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    input  logic                                    bus_cyc_i,
    input  logic                                    bus_we_i,
    input  l1_trig_pkg::bus_adr_t                   bus_adr_i,
    input  l1_trig_pkg::bus_dat_t                   bus_dat_i,
    output l1_trig_pkg::bus_dat_t                   bus_dat_o,
    output logic                                    bus_ack_o,
    input  l1_trig_pkg::beam_pow_t [`L1_NBEAMS-1:0] beam_pow_i,
    output l1_trig_pkg::beam_mask_t                 trigger_o,
    output logic                                    count_done_o
);
    import l1_trig_pkg::*;

    l1_bus_if thr_bus ();
    l1_bus_if scal_bus ();

    logic       bank;
    beam_mask_t subthresh;
    period_t    period;

    // address split and readback
    l1_reg_decode u_decode (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .bus_cyc_i (bus_cyc_i),
        .bus_we_i  (bus_we_i),
        .bus_adr_i (bus_adr_i),
        .bus_dat_i (bus_dat_i),
        .bus_dat_o (bus_dat_o),
        .bus_ack_o (bus_ack_o),
        .bank_i    (bank),
        .thr_m     (thr_bus.master),
        .scal_m    (scal_bus.master)
    );

    beam_thresh_trigger u_thresh (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .bus_s       (thr_bus.slave),
        .beam_pow_i  (beam_pow_i),
        .trigger_o   (trigger_o),
        .subthresh_o (subthresh),
        .period_o    (period)
    );

    beam_scaler u_scaler (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .bus_s        (scal_bus.slave),
        .trigger_i    (trigger_o),
        .subthresh_i  (subthresh),
        .period_i     (period),
        .count_done_o (count_done_o),
        .bank_o       (bank)
    );

endmodule

// ==== sim/l1_trigger_tb.sv ====
`include "l1_trig_cfg.svh"

module l1_trigger_tb;
    import l1_trig_pkg::*;

    localparam int N_PAT = 16;
    localparam int N_BUS = 24;
    localparam int SAT_CYCLES = 'h11000;
    localparam int TIMEOUT = 2 * N_PAT + 8 * N_BUS + SAT_CYCLES + 4 * `L1_PERIOD_RST + 200;
    // control registers in threshold space, address bit 11 set
    localparam bus_adr_t UPDATE_ADR = 13'h0c00;
    localparam bus_adr_t PERIOD_ADR = 13'h0c01;

    logic                        clk;
    logic                        rst_n;
    logic                        bus_cyc;
    logic                        bus_we;
    bus_adr_t                    bus_adr;
    bus_dat_t                    bus_dat;
    bus_dat_t                    bus_rdat;
    logic                        bus_ack;
    beam_pow_t [`L1_NBEAMS-1:0]  beam_pow;
    beam_mask_t                  trigger;
    logic                        count_done;

    logic [19:0] pat_mem [0:4*N_PAT-1];
    beam_pow_t   thr_val [2][`L1_NBEAMS];
    // masks now on the DUT outputs, and masks of the powers being driven
    beam_mask_t  cur_trig;
    beam_mask_t  cur_sub;
    beam_mask_t  next_trig;
    beam_mask_t  next_sub;
    int          acc [2][`L1_NBEAMS] = '{default: 0};
    int          last_hit [2][`L1_NBEAMS] = '{default: 0};
    int          snap [2][`L1_NBEAMS] = '{default: 0};
    int          done_cnt = 0;
    int          errors = 0;
    int          cycles = 0;

    l1_trigger_top i_l1_trigger_top (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .bus_cyc_i    (bus_cyc),
        .bus_we_i     (bus_we),
        .bus_adr_i    (bus_adr),
        .bus_dat_i    (bus_dat),
        .bus_dat_o    (bus_rdat),
        .bus_ack_o    (bus_ack),
        .beam_pow_i   (beam_pow),
        .trigger_o    (trigger),
        .count_done_o (count_done)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("ERROR: timeout after %0d cycles, the run did not finish", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // expected scaler counts over each period between two done pulses
    always @(negedge clk) begin
        int hit;
        if (rst_n) begin
            for (int s = 0; s < 2; s++) begin
                for (int b = 0; b < `L1_NBEAMS; b++) begin
                    hit = (s == 0) ? int'(cur_trig[b]) : int'(cur_sub[b]);
                    if (count_done) begin
                        snap[s][b] = acc[s][b] - last_hit[s][b];
                        acc[s][b] = last_hit[s][b];
                    end
                    acc[s][b] += hit;
                    last_hit[s][b] = hit;
                end
            end
            if (count_done) begin
                done_cnt++;
            end
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, actual, expected);
        end
    endtask

    // checks the mask of the previous cycle's powers, then drives new ones
    task automatic step_beams(input beam_pow_t p0, input beam_pow_t p1,
                              input beam_mask_t exp_trig, input beam_mask_t exp_sub);
        @(posedge clk);
        #1;
        cur_trig = next_trig;
        cur_sub = next_sub;
        check_value(32'(trigger), 32'(cur_trig), "trigger mask");
        beam_pow[0] = p0;
        beam_pow[1] = p1;
        next_trig = exp_trig;
        next_sub = exp_sub;
    endtask

    task automatic bus_xfer(input logic we, input bus_adr_t adr, input bus_dat_t wdat,
                            output bus_dat_t rdat);
        int waits;
        waits = 0;
        @(posedge clk);
        #1;
        bus_cyc = 1'b1;
        bus_we = we;
        bus_adr = adr;
        bus_dat = wdat;
        do begin
            @(posedge clk);
            #1;
            waits++;
        end while (!bus_ack);
        rdat = bus_rdat;
        bus_cyc = 1'b0;
        bus_we = 1'b0;
        check_value(32'(waits), 32'd1, "ack one cycle after cyc");
        @(posedge clk);
        #1;
        check_value(32'(bus_ack), 32'd0, "single ack pulse");
        repeat ($urandom_range(3, 0)) @(posedge clk);
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (!count_done);
    endtask

    initial begin
        bus_dat_t rd;
        logic     bank_prev;
        void'($urandom(48435));
        clk = 1'b0;
        rst_n = 1'b0;
        bus_cyc = 1'b0;
        bus_we = 1'b0;
        bus_adr = '0;
        bus_dat = '0;
        beam_pow = '0;
        cur_trig = '0;
        cur_sub = '0;
        next_trig = '0;
        next_sub = '0;
        $readmemh("sim/l1_trigger_patterns.txt", pat_mem);
        thr_val[0][0] = 18'h01000;
        thr_val[0][1] = 18'h02000;
        thr_val[1][0] = 18'h00800;
        thr_val[1][1] = 18'h01000;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // all-ones thresholds after reset, even full power stays quiet
        repeat (10) begin
            step_beams('1, '1, '0, '0);
            check_value(32'(count_done), 32'd0, "no done pulse after reset");
        end
        bus_xfer(1'b0, 13'h0000, '0, rd);
        check_value(rd, 32'd0, "scaler read after reset");

        for (int s = 0; s < 2; s++) begin
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                bus_xfer(1'b1, bus_adr_t'('h800 + s * 'h1000 + b), bus_dat_t'(thr_val[s][b]), rd);
            end
        end
        // pending thresholds are not live yet
        repeat (3) step_beams('1, '1, '0, '0);
        for (int s = 0; s < 2; s++) begin
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                bus_xfer(1'b0, bus_adr_t'('h800 + s * 'h1000 + b), '0, rd);
                check_value(rd, 32'(thr_val[s][b]), "pending threshold readback");
            end
        end
        bus_xfer(1'b1, PERIOD_ADR, 32'd8, rd);
        bus_xfer(1'b0, PERIOD_ADR, '0, rd);
        check_value(rd, 32'd8, "period readback");
        repeat (2) step_beams('0, '0, '0, '0);
        bus_xfer(1'b1, UPDATE_ADR, '0, rd);

        for (int i = 0; i < N_PAT; i++) begin
            step_beams(pat_mem[4*i][`L1_POW_W-1:0], pat_mem[4*i+1][`L1_POW_W-1:0],
                       pat_mem[4*i+2][`L1_NBEAMS-1:0], pat_mem[4*i+3][`L1_NBEAMS-1:0]);
        end
        repeat (3) step_beams('0, '0, '0, '0);

        // freeze the bank with a long period, then compare every scaler
        wait_done();
        bus_xfer(1'b1, PERIOD_ADR, 32'h000f_ffff, rd);
        for (int s = 0; s < 2; s++) begin
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                bus_xfer(1'b0, bus_adr_t'(s * 'h1000 + b), '0, rd);
                check_value(32'(rd[`L1_SCAL_W-1:0]), 32'(snap[s][b]), "scaler count");
                check_value(32'(rd[31]), 32'(done_cnt % 2), "bank bit");
            end
        end
        bank_prev = rd[31];
        bus_xfer(1'b1, PERIOD_ADR, 32'd8, rd);
        wait_done();
        bus_xfer(1'b0, 13'h0000, '0, rd);
        check_value(32'(rd[`L1_SCAL_W-1:0]), 32'(snap[0][0]), "scaler count next period");
        check_value(32'(rd[31]), 32'(!bank_prev), "bank toggles");

        // full power over a period longer than the scaler range
        repeat (2) step_beams('1, '1, 2'b11, 2'b11);
        bus_xfer(1'b1, PERIOD_ADR, bus_dat_t'(SAT_CYCLES), rd);
        wait_done();
        for (int b = 0; b < `L1_NBEAMS; b++) begin
            bus_xfer(1'b0, bus_adr_t'(b), '0, rd);
            check_value(32'(rd[`L1_SCAL_W-1:0]), 32'({`L1_SCAL_W{1'b1}}), "saturated scaler");
        end

        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sim/l1_trigger_patterns.txt ====
// columns: beam 0 power, beam 1 power, expected trigger mask, expected subthreshold mask
// hex values, bit 0 of each mask is beam 0
00000 00000 0 0
00800 01000 0 0
00801 01001 0 3
01000 02000 0 3
01001 00000 1 1
00000 02001 2 2
01001 02001 3 3
3ffff 3ffff 3 3
00fff 01fff 0 3
007ff 00fff 0 0
20000 00001 1 1
00001 10000 2 2
00900 03000 2 3
05000 01800 1 3
00000 00000 0 0
12345 00abc 1 1

// ==== compile.f ====
+incdir+verilog
verilog/l1_trig_pkg.sv
verilog/l1_bus_if.sv
verilog/l1_reg_decode.sv
verilog/beam_thresh_trigger.sv
verilog/beam_scaler.sv
verilog/l1_trigger_top.sv
sim/l1_trigger_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the l1 trigger testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f compile.f --top-module l1_trigger_tb -o l1_trigger_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/l1_trigger_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0
